// ==== hdl/periph_pkg.sv ====
package periph_pkg;

    // ------------------------------------------------------------------
    // Bus geometry
    // ------------------------------------------------------------------
    localparam int DataWidth    = 32;
    localparam int AddrWidth    = 16;
    localparam int BeWidth      = DataWidth / 8;
    localparam int WordIdxWidth = 10;
    localparam int GpioWidth    = 8;    // LEDs and DIP switches

    // Region codes from address bits [13:12]
    localparam logic [1:0] RegionBoot = 2'd0;
    localparam logic [1:0] RegionGpio = 2'd1;
    localparam logic [1:0] RegionUart = 2'd2;  // Unmapped
    localparam logic [1:0] RegionEth  = 2'd3;  // Unmapped

    // Boot RAM
    localparam int    BootDepth     = 32;
    localparam int    BootAddrWidth = $clog2(BootDepth);
    localparam string BootFile      = "bootram.hex";

    // GPIO register word indices
    localparam logic [WordIdxWidth-1:0] RegLedDip    = 10'd0;
    localparam logic [WordIdxWidth-1:0] RegRngData   = 10'd2;
    localparam logic [WordIdxWidth-1:0] RegRngStatus = 10'd3;

    localparam logic [DataWidth-1:0] BadData = 32'hDEAD_BEEF;

    // Random number FIFO
    localparam int RngDepth      = 8;
    localparam int RngCountWidth = 4;
    localparam int RngPtrWidth   = $clog2(RngDepth);
    localparam logic [DataWidth-1:0] LfsrSeed = 32'hACE1_2468;
    localparam logic [DataWidth-1:0] LfsrTaps = 32'h8020_0003;  // Galois mask

    // ------------------------------------------------------------------
    // Bus types
    // ------------------------------------------------------------------
    typedef struct packed {
        logic [1:0]              reserved;
        logic [1:0]              region;
        logic [WordIdxWidth-1:0] word_idx;
        logic [1:0]              byte_off;
    } bus_addr_fields_t;

    typedef union packed {
        logic [AddrWidth-1:0] raw;
        bus_addr_fields_t     fields;
    } bus_addr_u;

    typedef struct packed {
        logic                 we;
        bus_addr_u            addr;
        logic [BeWidth-1:0]   be;
        logic [DataWidth-1:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic [DataWidth-1:0] rdata;
        logic                 err;
    } bus_rsp_t;

    typedef struct packed {
        logic                                 full;
        logic                                 empty;
        logic [DataWidth-RngCountWidth-3:0]   pad;
        logic [RngCountWidth-1:0]             count;
    } rng_status_t;

endpackage

// ==== hdl/rng_fifo.sv ====
`timescale 1ns/1ps

module rng_fifo
    import periph_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 pop_i,
    output logic [DataWidth-1:0] head_o,
    output rng_status_t          status_o
);

    logic [DataWidth-1:0]     buf_q [RngDepth];
    logic [RngPtrWidth-1:0]   wr_ptr_q;
    logic [RngPtrWidth-1:0]   rd_ptr_q;
    logic [RngCountWidth-1:0] count_q;
    logic [DataWidth-1:0]     lfsr_q;
    logic [DataWidth-1:0]     lfsr_next;
    logic                     full;
    logic                     empty;
    logic                     push;
    logic                     pop;

    assign full  = (count_q == RngCountWidth'(RngDepth));
    assign empty = (count_q == '0);
    assign push  = !full;           // Top up whenever there is room
    assign pop   = pop_i && !empty;

    // Galois step, shift right and fold in taps on a one out
    assign lfsr_next = lfsr_q[0] ? ((lfsr_q >> 1) ^ LfsrTaps) : (lfsr_q >> 1);

    // ------------------------------------------------------------------
    // Pointers, count and generator
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            lfsr_q   <= LfsrSeed;
        end
        else
        begin
            if (push)
            begin
                wr_ptr_q <= wr_ptr_q + 1'b1;   // Wraps at RngDepth
                lfsr_q   <= lfsr_next;
            end
            if (pop)
                rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (push)
            buf_q[wr_ptr_q] <= lfsr_q;
    end

    assign head_o         = buf_q[rd_ptr_q];
    assign status_o.full  = full;
    assign status_o.empty = empty;
    assign status_o.pad   = '0;
    assign status_o.count = count_q;

    a_count_bound: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        count_q <= RngCountWidth'(RngDepth)
    );

    // Count tracks the pointer distance, so a push never lands on an unread word
    a_no_push_full: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (wr_ptr_q - rd_ptr_q) == count_q[RngPtrWidth-1:0]
    );

endmodule

// ==== hdl/boot_ram.sv ====
`timescale 1ns/1ps

module boot_ram
    import periph_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 req_i,
    input  bus_req_t             req_data_i,
    output logic [DataWidth-1:0] rdata_o
);

    logic [DataWidth-1:0]     mem_q [BootDepth];
    logic [BootAddrWidth-1:0] idx;

    // Upper word index bits alias onto the same words
    assign idx = req_data_i.addr.fields.word_idx[BootAddrWidth-1:0];

    initial
    begin
        $readmemh(BootFile, mem_q);
    end

    always_ff @(posedge clk_i)
    begin
        if (req_i)
        begin
            if (req_data_i.we)
            begin
                for (int b = 0; b < BeWidth; b++)
                begin
                    if (req_data_i.be[b])
                        mem_q[idx][8*b +: 8] <= req_data_i.wdata[8*b +: 8];
                end
            end
            else
            begin
                rdata_o <= mem_q[idx];  // Registered read
            end
        end
    end

    // Masterside contract
    a_write_has_be: assert property (
        @(posedge clk_i)
        (req_i && req_data_i.we) |-> (req_data_i.be != '0)
    );

endmodule

// ==== hdl/gpio_regs.sv ====
`timescale 1ns/1ps

module gpio_regs
    import periph_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 req_i,
    input  bus_req_t             req_data_i,
    input  logic [GpioWidth-1:0] dip_switches_i,
    output logic [GpioWidth-1:0] leds_o,
    output logic [DataWidth-1:0] rdata_o
);

    logic [WordIdxWidth-1:0] idx;
    logic [WordIdxWidth-1:0] idx_q;     // Selects the read data
    logic                    wr_en;
    logic                    rng_pop;
    logic [DataWidth-1:0]    rng_head;
    rng_status_t             rng_status;
    logic [GpioWidth-1:0]    leds_q;

    assign idx   = req_data_i.addr.fields.word_idx;
    assign wr_en = req_i && req_data_i.we;

    // ------------------------------------------------------------------
    // Write side
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
            leds_q <= '0;
        else if (wr_en && (idx == RegLedDip))
            leds_q <= req_data_i.wdata[GpioWidth-1:0];   // Low byte only
    end

    always_ff @(posedge clk_i)
    begin
        if (req_i)
            idx_q <= idx;
    end

    // Write to the data register consumes the head word
    assign rng_pop = wr_en && (idx == RegRngData);

    assign leds_o = leds_q;

    rng_fifo i_rng_fifo (
        .clk_i    ( clk_i      ),
        .rst_n_i  ( rst_n_i    ),
        .pop_i    ( rng_pop    ),
        .head_o   ( rng_head   ),
        .status_o ( rng_status )
    );

    // ------------------------------------------------------------------
    // Read side
    // ------------------------------------------------------------------
    always_comb
    begin
        case (idx_q)
            RegLedDip:
                rdata_o = {{(DataWidth-GpioWidth){1'b0}}, dip_switches_i};
            RegRngData:
                rdata_o = rng_head;
            RegRngStatus:
                rdata_o = rng_status;
            default:
                rdata_o = BadData;  // No error flag here
        endcase
    end

    // Software must not drain the FIFO below empty
    a_no_pop_when_empty: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        rng_pop |-> !rng_status.empty
    );

endmodule

// ==== hdl/periph_addr_decode.sv ====
`timescale 1ns/1ps

module periph_addr_decode
    import periph_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 req_i,
    input  bus_req_t             req_data_i,
    output logic                 ram_req_o,
    output logic                 gpio_req_o,
    input  logic [DataWidth-1:0] ram_rdata_i,
    input  logic [DataWidth-1:0] gpio_rdata_i,
    output logic                 rvalid_o,
    output bus_rsp_t             rsp_o
);

    logic [1:0] region;
    logic [1:0] region_q;   // Region of the request in flight
    logic       we_q;
    logic       rvalid_q;

    assign region = req_data_i.addr.fields.region;  // Reserved bits ignored

    // ------------------------------------------------------------------
    // Request steering
    // ------------------------------------------------------------------
    assign ram_req_o  = req_i && (region == RegionBoot);
    assign gpio_req_o = req_i && (region == RegionGpio);

    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
        begin
            rvalid_q <= 1'b0;
            region_q <= RegionBoot;
            we_q     <= 1'b0;
        end
        else
        begin
            rvalid_q <= req_i;
            if (req_i)
            begin
                region_q <= region;
                we_q     <= req_data_i.we;
            end
        end
    end

    // ------------------------------------------------------------------
    // Response selection
    // ------------------------------------------------------------------
    always_comb
    begin
        rsp_o.rdata = '0;   // Mapped writes return zero
        rsp_o.err   = 1'b0;
        case (region_q)
            RegionBoot:
            begin
                if (!we_q)
                    rsp_o.rdata = ram_rdata_i;
            end
            RegionGpio:
            begin
                if (!we_q)
                    rsp_o.rdata = gpio_rdata_i;
            end
            default:
            begin
                // UART and Ethernet slots answer with an error
                rsp_o.rdata = BadData;
                rsp_o.err   = 1'b1;
            end
        endcase
    end

    assign rvalid_o = rvalid_q;

endmodule

// ==== hdl/periph_top.sv ====
`timescale 1ns/1ps

module periph_top
    import periph_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 req_i,
    input  bus_req_t             req_data_i,
    output logic                 rvalid_o,
    output bus_rsp_t             rsp_o,
    input  logic [GpioWidth-1:0] dip_switches_i,
    output logic [GpioWidth-1:0] leds_o
);

    logic                 ram_req;
    logic                 gpio_req;
    logic [DataWidth-1:0] ram_rdata;
    logic [DataWidth-1:0] gpio_rdata;

    // Region steering and response mux
    periph_addr_decode i_periph_addr_decode (
        .clk_i        ( clk_i      ),
        .rst_n_i      ( rst_n_i    ),
        .req_i        ( req_i      ),
        .req_data_i   ( req_data_i ),
        .ram_req_o    ( ram_req    ),
        .gpio_req_o   ( gpio_req   ),
        .ram_rdata_i  ( ram_rdata  ),
        .gpio_rdata_i ( gpio_rdata ),
        .rvalid_o     ( rvalid_o   ),
        .rsp_o        ( rsp_o      )
    );

    boot_ram i_boot_ram (
        .clk_i      ( clk_i      ),
        .req_i      ( ram_req    ),
        .req_data_i ( req_data_i ),
        .rdata_o    ( ram_rdata  )
    );

    gpio_regs i_gpio_regs (
        .clk_i          ( clk_i          ),
        .rst_n_i        ( rst_n_i        ),
        .req_i          ( gpio_req       ),
        .req_data_i     ( req_data_i     ),
        .dip_switches_i ( dip_switches_i ),
        .leds_o         ( leds_o         ),
        .rdata_o        ( gpio_rdata     )
    );

endmodule

// ==== verification/periph_tb.sv ====
`timescale 1ns/1ps

module periph_tb
    import periph_pkg::*;
();

    localparam int MaxCycles = 5000;    // Roughly 700 transactions with idle gaps and margin

    logic                 clk_i;
    logic                 rst_n_i;
    logic                 req_i;
    bus_req_t             req_data_i;
    logic                 rvalid_o;
    bus_rsp_t             rsp_o;
    logic [GpioWidth-1:0] dip_switches_i;
    logic [GpioWidth-1:0] leds_o;

    integer               seed = 32'h47e8_e49c;
    int                   cycle_cnt = 0;

    // Reference model state
    logic [DataWidth-1:0] ram_model [BootDepth];
    logic [DataWidth-1:0] rng_q [$];    // Words the FIFO should hold, oldest first
    logic [DataWidth-1:0] lfsr_model;
    logic [GpioWidth-1:0] led_model;
    bus_req_t             pend_q [$];   // Requests waiting for their response

    periph_top i_periph_top (
        .clk_i          ( clk_i          ),
        .rst_n_i        ( rst_n_i        ),
        .req_i          ( req_i          ),
        .req_data_i     ( req_data_i     ),
        .rvalid_o       ( rvalid_o       ),
        .rsp_o          ( rsp_o          ),
        .dip_switches_i ( dip_switches_i ),
        .leds_o         ( leds_o         )
    );

    initial
    begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    always @(posedge clk_i)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == MaxCycles)
            fail_run($sformatf("Simulation timed out after %0d cycles", MaxCycles));
    end

    // ------------------------------------------------------------------
    // Checking
    // ------------------------------------------------------------------
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected)
            fail_run($sformatf("Fail at %0t: %s is %h, expected %h",
                               $time, what, actual, expected));
    endtask

    function automatic logic [DataWidth-1:0] lfsr_advance(input logic [DataWidth-1:0] v);
        logic [DataWidth-1:0] nxt;
        nxt = v >> 1;
        if (v[0])
            nxt = nxt ^ LfsrTaps;   // Bit shifted out was one
        return nxt;
    endfunction

    function automatic logic [BootAddrWidth-1:0] boot_index(input bus_req_t rq);
        return BootAddrWidth'(rq.addr.fields.word_idx % WordIdxWidth'(BootDepth));
    endfunction

    function automatic bus_rsp_t expected_rsp(input bus_req_t rq);
        bus_rsp_t                rsp;
        rng_status_t             st;
        logic [WordIdxWidth-1:0] idx;
        rsp.rdata = '0;
        rsp.err   = 1'b0;
        idx       = rq.addr.fields.word_idx;
        st.full   = (rng_q.size() == RngDepth);
        st.empty  = (rng_q.size() == 0);
        st.pad    = '0;
        st.count  = RngCountWidth'(rng_q.size());
        case (rq.addr.fields.region)
            RegionBoot:
            begin
                if (!rq.we)
                    rsp.rdata = ram_model[boot_index(rq)];
            end
            RegionGpio:
            begin
                if (!rq.we)
                begin
                    case (idx)
                        RegLedDip:    rsp.rdata = DataWidth'(dip_switches_i);
                        RegRngData:   rsp.rdata = rng_q[0];
                        RegRngStatus: rsp.rdata = st;
                        default:      rsp.rdata = BadData;
                    endcase
                end
            end
            default:
            begin
                rsp.rdata = BadData;
                rsp.err   = 1'b1;
            end
        endcase
        return rsp;
    endfunction

    // Sampled mid-cycle, after the edge that launched the response
    task automatic check_response();
        bus_req_t rq;
        bus_rsp_t exp_rsp;
        if (pend_q.size() == 0)
        begin
            if (rvalid_o !== 1'b0)
                fail_run("rvalid_o is high although no request is outstanding");
        end
        else
        begin
            if (rvalid_o !== 1'b1)
                fail_run("rvalid_o is missing one cycle after a request");
            rq      = pend_q.pop_front();
            exp_rsp = expected_rsp(rq);
            check_value(rsp_o.rdata, exp_rsp.rdata,
                        $sformatf("rdata for %s at %h", rq.we ? "write" : "read", rq.addr.raw));
            check_value(32'(rsp_o.err), 32'(exp_rsp.err),
                        $sformatf("err for %s at %h", rq.we ? "write" : "read", rq.addr.raw));
        end
        check_value(32'(leds_o), 32'(led_model), "leds_o");
    endtask

    // ------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------
    task automatic make_req(input logic we, input logic [1:0] region,
                            input logic [WordIdxWidth-1:0] idx, output bus_req_t rq);
        rq.we                   = we;
        rq.addr.fields.reserved = 2'($random(seed));     // Ignored by the decoder
        rq.addr.fields.region   = region;
        rq.addr.fields.word_idx = idx;
        rq.addr.fields.byte_off = 2'($random(seed));
        rq.be                   = BeWidth'($random(seed));
        rq.wdata                = $random(seed);
        if (rq.be == '0)
            rq.be = '1;     // Writes need at least one lane
    endtask

    // Model update for one rising edge
    task automatic model_edge(input logic vld, input bus_req_t rq);
        logic [DataWidth-1:0]    mask;
        logic [WordIdxWidth-1:0] idx;
        logic                    do_push;
        logic                    do_pop;
        logic                    gpio_wr;
        idx     = rq.addr.fields.word_idx;
        gpio_wr = vld && rq.we && (rq.addr.fields.region == RegionGpio);
        do_push = (rng_q.size() < RngDepth);
        do_pop  = gpio_wr && (idx == RegRngData) && (rng_q.size() != 0);
        mask    = {{8{rq.be[3]}}, {8{rq.be[2]}}, {8{rq.be[1]}}, {8{rq.be[0]}}};
        if (vld && rq.we && (rq.addr.fields.region == RegionBoot))
            ram_model[boot_index(rq)] = (ram_model[boot_index(rq)] & ~mask) | (rq.wdata & mask);
        if (gpio_wr && (idx == RegLedDip))
            led_model = rq.wdata[GpioWidth-1:0];
        if (do_pop)
            void'(rng_q.pop_front());
        if (do_push)
        begin
            rng_q.push_back(lfsr_model);    // Pushed value is taken before the step
            lfsr_model = lfsr_advance(lfsr_model);
        end
        if (vld)
            pend_q.push_back(rq);
    endtask

    // One bus cycle, entered and left 1 ns after a rising edge
    task automatic issue(input logic vld, input bus_req_t rq);
        bus_req_t drv;
        drv = rq;
        if (vld && rq.we && (rq.addr.fields.region == RegionGpio)
            && (rq.addr.fields.word_idx == RegRngData) && (rng_q.size() == 0))
            drv.we = 1'b0;  // Never pop an empty FIFO
        req_i          = vld;
        req_data_i     = drv;
        dip_switches_i = GpioWidth'($random(seed));
        @(negedge clk_i);
        check_response();
        @(posedge clk_i);
        model_edge(vld, drv);
        #1;
    endtask

    task automatic idle(input int n);
        bus_req_t rq;
        repeat (n)
        begin
            make_req(1'b1, 2'($random(seed)), WordIdxWidth'($random(seed)), rq);
            issue(1'b0, rq);    // Payload must be ignored without req_i
        end
    endtask

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------
    initial
    begin
        bus_req_t                rq;
        logic [31:0]             r;
        logic [WordIdxWidth-1:0] idx;
        rst_n_i        = 1'b0;
        req_i          = 1'b0;
        req_data_i     = '0;
        dip_switches_i = '0;
        led_model      = '0;
        lfsr_model     = LfsrSeed;
        $readmemh("bootram.hex", ram_model);
        repeat (2) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;

        // Preloaded words, then two aliased indices
        for (int i = 0; i < BootDepth; i++)
        begin
            make_req(1'b0, RegionBoot, WordIdxWidth'(i), rq);
            issue(1'b1, rq);
        end
        make_req(1'b0, RegionBoot, 10'd37, rq);
        issue(1'b1, rq);
        make_req(1'b0, RegionBoot, 10'h3e1, rq);
        issue(1'b1, rq);

        repeat (60)
        begin
            idx = WordIdxWidth'($random(seed));
            make_req(1'b1, RegionBoot, idx, rq);
            issue(1'b1, rq);
            make_req(1'b0, RegionBoot, idx ^ 10'h3e0, rq);  // Read back through an alias
            issue(1'b1, rq);
        end
        for (int i = 0; i < BootDepth; i++)
        begin
            make_req(1'b0, RegionBoot, WordIdxWidth'(i), rq);
            issue(1'b1, rq);
        end

        repeat (20)
        begin
            make_req(1'b1, RegionGpio, RegLedDip, rq);
            issue(1'b1, rq);
            make_req(1'b0, RegionGpio, RegLedDip, rq);
            issue(1'b1, rq);
        end

        // RNG FIFO should be full by now, drain it in order
        idle(RngDepth + 2);
        make_req(1'b0, RegionGpio, RegRngStatus, rq);
        issue(1'b1, rq);
        repeat (2 * RngDepth)
        begin
            make_req(1'b0, RegionGpio, RegRngData, rq);
            issue(1'b1, rq);
            make_req(1'b1, RegionGpio, RegRngData, rq);
            issue(1'b1, rq);
        end
        make_req(1'b0, RegionGpio, RegRngStatus, rq);
        issue(1'b1, rq);

        repeat (40)
        begin
            r = $random(seed);
            make_req(r[0], r[1] ? RegionEth : RegionUart, r[31:22], rq);
            issue(1'b1, rq);
        end
        repeat (10)
        begin
            r   = $random(seed);
            idx = r[31:22];
            if ((idx == RegLedDip) || (idx == RegRngData) || (idx == RegRngStatus))
                idx = 10'd1;
            make_req(r[0], RegionGpio, idx, rq);
            issue(1'b1, rq);
        end

        // Back-to-back mixed traffic with occasional idle cycles
        repeat (300)
        begin
            r   = $random(seed);
            idx = r[2] ? {8'b0, r[4:3]} : r[31:22];
            make_req(r[5], r[1:0], idx, rq);
            issue(r[8:6] != 3'd0, rq);
        end
        idle(2);

        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== bootram.hex ====
// Boot RAM image, one 32-bit hex word per line, word 0 first
3c1d0000
27bd1ff0
0c000010
00000000
8fa40000
24a50004
00a42021
14800003
ac850008
3c08a5a5
3508c3c3
01094026
11000005
24090020
2529ffff
1520fffe
00000000
03e00008
afbf0014
afb00010
00808021
0c000024
24040001
8fbf0014
8fb00010
27bd0018
12345678
9abcdef0
0f1e2d3c
4b5a6978
c0ffee11
5eed1e55

// ==== sim.f ====
hdl/periph_pkg.sv
hdl/rng_fifo.sv
hdl/boot_ram.sv
hdl/gpio_regs.sv
hdl/periph_addr_decode.sv
hdl/periph_top.sv
verification/periph_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the peripheral testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f sim.f --top-module periph_tb -o periph_sim

# A failing run still leaves its log for the check below
./obj_dir/periph_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Simulation passed$" sim.log
then
    echo "Result: PASS"
else
    echo "Result: FAIL"
    exit 1
fi
